/* exceptionUnit.f */
hdl/excCtrlPkg.sv
hdl/pipeStagePkg.sv
hdl/excSequencer.sv
hdl/drainCounter.sv
hdl/causePipe.sv
hdl/vectorSelect.sv
hdl/exceptionUnit.sv
tb/tbClockGen.sv
tb/exceptionUnit_asserts.sv
tb/exceptionUnit_tb.sv

/* hdl/causePipe.sv */
`timescale 1ns/1ps

module causePipe (
  input  logic                clk,
  input  logic                reset,
  input  logic                undefE,
  input  logic                swiE,
  input  logic                prefetchAbortE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                stallE,
  input  logic                pcUpdateW,
  input  logic                clearM,
  input  logic                clearW,
  output excCtrlPkg::excCause causeW,
  output logic                unstallD
);

  excCtrlPkg::excCause causeE, causeM;

  // Prefetch abort outranks the other E-stage causes
  always_comb begin
    if (prefetchAbortE)  causeE = excCtrlPkg::prefetchAbort;
    else if (undefE)     causeE = excCtrlPkg::undef;
    else if (swiE)       causeE = excCtrlPkg::swi;
    else                 causeE = excCtrlPkg::none;
  end

  // Cause rides with the instruction, clear only acts on an enabled step
  always_ff @(posedge clk) begin
    if (reset) begin
      causeM <= excCtrlPkg::none;
    end else if (!stallM) begin
      causeM <= clearM ? excCtrlPkg::none : causeE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      causeW <= excCtrlPkg::none;
    end else if (!stallW) begin
      causeW <= clearW ? excCtrlPkg::none : causeM;
    end
  end

  // W instruction wrote the PC, so D may take the new target
  always_ff @(posedge clk) begin
    if (reset)        unstallD <= 1'b0;
    else if (!stallE) unstallD <= pcUpdateW;
  end

endmodule

/* hdl/drainCounter.sv */
`timescale 1ns/1ps

module drainCounter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   drainStart,
  input  logic                   stallE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   pcWrPendingF,
  output pipeStagePkg::pipeStage drainStage,
  output logic                   drainDone
);

  logic holdE;

  // A pending PC write freezes the pipe until W, same as a stall in E
  assign holdE = stallE | pcWrPendingF;

  // Tracks where the last good instruction sits while draining
  always_ff @(posedge clk) begin
    if (reset) begin
      // Parked at W when no drain is running
      drainStage <= pipeStagePkg::stageW;
    end else if (drainStart) begin
      drainStage <= pipeStagePkg::stageE;
    end else begin
      case (drainStage)
        pipeStagePkg::stageE: begin
          if (!holdE) drainStage <= pipeStagePkg::stageM;
        end
        pipeStagePkg::stageM: begin
          if (!stallM) drainStage <= pipeStagePkg::stageW;
        end
        default: begin
          // Saturate at W
          drainStage <= pipeStagePkg::stageW;
        end
      endcase
    end
  end

  // Instruction is leaving W this cycle
  assign drainDone = (drainStage == pipeStagePkg::stageW) & ~stallW;

endmodule

/* hdl/excCtrlPkg.sv */
package excCtrlPkg;

  // Width of the vector code sent to the fetch mux
  localparam int vecBits = 3;

  // Width of one cause field in the cause pipe
  localparam int causeBits = 3;

  // Sequencer states
  // One drain state replaces the per-stage interrupt states
  typedef enum logic [2:0] {
    idle,
    abortSecond,
    drain,
    excM,
    excW
  } excState;

  // Cause codes carried down the pipe and seen by the vector selector
  typedef enum logic [causeBits-1:0] {
    none          = 3'd0,
    undef         = 3'd1,
    swi           = 3'd2,
    prefetchAbort = 3'd3,
    dataAbort     = 3'd4,
    irq           = 3'd5,
    fiq           = 3'd6,
    reset         = 3'd7
  } excCause;

  // Vector codes, word offset of the ARM vector table entry
  localparam logic [vecBits-1:0] vecReset    = 3'd0;
  localparam logic [vecBits-1:0] vecUndef    = 3'd1;
  localparam logic [vecBits-1:0] vecSwi      = 3'd2;
  localparam logic [vecBits-1:0] vecPrefetch = 3'd3;
  localparam logic [vecBits-1:0] vecData     = 3'd4;
  // Entry 5 is the unused address exception slot
  localparam logic [vecBits-1:0] vecIrq      = 3'd6;
  localparam logic [vecBits-1:0] vecFiq      = 3'd7;

endpackage

/* hdl/excSequencer.sv */
`timescale 1ns/1ps

module excSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   undefE,
  input  logic                   swiE,
  input  logic                   prefetchAbortE,
  input  logic                   dataAbortM,
  input  logic                   fiqReq,
  input  logic                   irqReq,
  input  logic                   fiqEnabled,
  input  logic                   irqEnabled,
  input  logic                   stallD,
  input  logic                   stallE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   pcWrPendingF,
  input  logic                   unstallD,
  input  pipeStagePkg::pipeStage drainStage,
  input  logic                   drainDone,
  output logic                   flushD,
  output logic                   flushE,
  output logic                   flushM,
  output logic                   flushW,
  output logic                   stallOutD,
  output logic                   resetMicrop,
  output logic                   interrupting,
  output logic                   clearM,
  output logic                   clearW,
  output logic                   drainStart,
  output logic                   abortSecond,
  output logic                   fiqTake,
  output logic                   irqTake,
  output logic                   fiqAck,
  output logic                   irqAck
);

  excCtrlPkg::excState state, nextState;
  logic [pipeStagePkg::flushBits-1:0] flushVec;
  logic fiqEnSync, irqEnSync;
  logic fiqPending, irqPending, intPending;
  logic excE;

  // CPSR updates on the falling edge, so sample the enables on the rising one
  always_ff @(posedge clk) begin
    if (reset) begin
      fiqEnSync <= 1'b0;
      irqEnSync <= 1'b0;
    end else begin
      fiqEnSync <= fiqEnabled;
      irqEnSync <= irqEnabled;
    end
  end

  // Any exception raised by the instruction now in E
  assign excE = undefE | swiE | prefetchAbortE;

  // Request masked while its ack is still up
  assign fiqPending = fiqReq & fiqEnSync & ~fiqAck;
  assign irqPending = irqReq & irqEnSync & ~irqAck;
  // E-stage exceptions win over interrupt entry
  assign intPending = (fiqPending | irqPending) & ~excE;

  always_ff @(posedge clk) begin
    if (reset) state <= excCtrlPkg::idle;
    else       state <= nextState;
  end

  // Mealy next state and flush logic, flushVec is {D, E, M, W}
  always_comb begin
    nextState  = state;
    flushVec   = '0;
    stallOutD  = 1'b0;
    drainStart = 1'b0;
    case (state)
      excCtrlPkg::idle: begin
        if (dataAbortM) begin
          // Abort caught in M, kill everything and hold D
          flushVec  = 4'b1111;
          stallOutD = 1'b1;
          nextState = excCtrlPkg::abortSecond;
        end else if (excE) begin
          // Last good instruction in M may still set flags
          flushVec  = 4'b1110;
          stallOutD = 1'b1;
          if (!stallM) nextState = excCtrlPkg::excM;
        end else if (intPending && !stallD && !pcWrPendingF) begin
          // Hold off while a PC write is in flight from F
          drainStart = 1'b1;
          nextState  = excCtrlPkg::drain;
        end
      end
      excCtrlPkg::abortSecond: begin
        // Second abort cycle, PC gets saved here
        flushVec  = 4'b1011;
        nextState = excCtrlPkg::idle;
      end
      excCtrlPkg::excM: begin
        flushVec  = 4'b0100;
        stallOutD = 1'b1;
        if (!stallW) nextState = excCtrlPkg::excW;
      end
      excCtrlPkg::excW: begin
        // Cause reaches W, vector goes out this cycle
        flushVec = 4'b1000;
        if (!stallE) nextState = excCtrlPkg::idle;
      end
      excCtrlPkg::drain: begin
        case (drainStage)
          pipeStagePkg::stageE: begin
            flushVec  = 4'b0100;
            stallOutD = 1'b1;
          end
          pipeStagePkg::stageM: begin
            // Let a branch target into D when the W instruction wrote the PC
            flushVec  = 4'b0100;
            stallOutD = ~unstallD;
          end
          default: begin
            flushVec = 4'b1000;
          end
        endcase
        // Dropped request cancels the drain quietly
        if (!intPending || drainDone) nextState = excCtrlPkg::idle;
      end
      default: nextState = excCtrlPkg::idle;
    endcase
  end

  assign {flushD, flushE, flushM, flushW} = flushVec;

  // Take happens as the last good instruction leaves W, FIQ first
  assign fiqTake = (state == excCtrlPkg::drain) & drainDone & fiqPending & ~excE;
  assign irqTake = (state == excCtrlPkg::drain) & drainDone & irqPending & ~fiqPending & ~excE;

  // Four-phase acks, up the cycle after take and down the cycle after req falls
  always_ff @(posedge clk) begin
    if (reset) begin
      fiqAck <= 1'b0;
      irqAck <= 1'b0;
    end else begin
      fiqAck <= fiqTake | (fiqAck & fiqReq);
      irqAck <= irqTake | (irqAck & irqReq);
    end
  end

  assign abortSecond  = (state == excCtrlPkg::abortSecond);
  assign resetMicrop  = (state == excCtrlPkg::idle) & dataAbortM;
  assign interrupting = (state != excCtrlPkg::idle) | excE;

  // Cause pipe only loads M from idle and W from excM
  assign clearM = (state != excCtrlPkg::idle);
  assign clearW = (state != excCtrlPkg::excM);

endmodule

/* hdl/exceptionUnit.sv */
`timescale 1ns/1ps

module exceptionUnit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           undefE,
  input  logic                           swiE,
  input  logic                           prefetchAbortE,
  input  logic                           dataAbortM,
  input  logic                           stallD,
  input  logic                           stallE,
  input  logic                           stallM,
  input  logic                           stallW,
  input  logic                           pcWrPendingF,
  input  logic                           pcUpdateW,
  input  logic                           irqEnabled,
  input  logic                           fiqEnabled,
  input  logic                           fiqReq,
  input  logic                           irqReq,
  output logic                           fiqAck,
  output logic                           irqAck,
  output logic                           flushD,
  output logic                           flushE,
  output logic                           flushM,
  output logic                           flushW,
  output logic                           stallOutD,
  output logic                           resetMicrop,
  output logic                           interrupting,
  output logic [excCtrlPkg::vecBits-1:0] vectorCode,
  output pipeStagePkg::pcSel             pcSelect,
  output logic                           savePc
);

  logic clearM, clearW, unstallD;
  logic drainStart, drainDone;
  logic abortSecond, fiqTake, irqTake;
  pipeStagePkg::pipeStage drainStage;
  excCtrlPkg::excCause causeW;

  // Control FSM and interrupt handshake
  excSequencer seq0 (
    .clk(clk), .reset(reset),
    .undefE(undefE), .swiE(swiE), .prefetchAbortE(prefetchAbortE),
    .dataAbortM(dataAbortM), .fiqReq(fiqReq), .irqReq(irqReq),
    .fiqEnabled(fiqEnabled), .irqEnabled(irqEnabled),
    .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .pcWrPendingF(pcWrPendingF), .unstallD(unstallD),
    .drainStage(drainStage), .drainDone(drainDone),
    .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .stallOutD(stallOutD), .resetMicrop(resetMicrop), .interrupting(interrupting),
    .clearM(clearM), .clearW(clearW), .drainStart(drainStart),
    .abortSecond(abortSecond), .fiqTake(fiqTake), .irqTake(irqTake),
    .fiqAck(fiqAck), .irqAck(irqAck)
  );

  drainCounter drain0 (
    .clk(clk), .reset(reset), .drainStart(drainStart),
    .stallE(stallE), .stallM(stallM), .stallW(stallW), .pcWrPendingF(pcWrPendingF),
    .drainStage(drainStage), .drainDone(drainDone)
  );

  causePipe cause0 (
    .clk(clk), .reset(reset),
    .undefE(undefE), .swiE(swiE), .prefetchAbortE(prefetchAbortE),
    .stallM(stallM), .stallW(stallW), .stallE(stallE), .pcUpdateW(pcUpdateW),
    .clearM(clearM), .clearW(clearW), .causeW(causeW), .unstallD(unstallD)
  );

  vectorSelect vec0 (
    .reset(reset), .fiqTake(fiqTake), .irqTake(irqTake),
    .abortSecond(abortSecond), .causeW(causeW),
    .vectorCode(vectorCode), .pcSelect(pcSelect), .savePc(savePc)
  );

endmodule

/* hdl/pipeStagePkg.sv */
package pipeStagePkg;

  // Number of stages the unit can flush (D, E, M, W)
  localparam int flushBits = 4;

  // Stage holding the last good instruction during a drain
  typedef enum logic [1:0] {
    stageE = 2'd0,
    stageM = 2'd1,
    stageW = 2'd2
  } pipeStage;

  // PC value to save into the link register
  typedef enum logic [1:0] {
    // Normal flow
    pcPlus8 = 2'b00,
    // Exceptions and data abort
    pcPlus0 = 2'b01,
    // FIQ and IRQ
    pcPlus4 = 2'b10
  } pcSel;

endpackage

/* hdl/vectorSelect.sv */
`timescale 1ns/1ps

module vectorSelect (
  input  logic                             reset,
  input  logic                             fiqTake,
  input  logic                             irqTake,
  input  logic                             abortSecond,
  input  excCtrlPkg::excCause              causeW,
  output logic [excCtrlPkg::vecBits-1:0]   vectorCode,
  output pipeStagePkg::pcSel               pcSelect,
  output logic                             savePc
);

  excCtrlPkg::excCause active;

  // Priority: reset, fiq, irq, data abort, then whatever sits in W
  always_comb begin
    if (reset)            active = excCtrlPkg::reset;
    else if (fiqTake)     active = excCtrlPkg::fiq;
    else if (irqTake)     active = excCtrlPkg::irq;
    else if (abortSecond) active = excCtrlPkg::dataAbort;
    // Cause pipe already ordered prefetch abort, swi and undef
    else                  active = causeW;
  end

  // Vector and saved PC for the chosen cause
  always_comb begin
    case (active)
      excCtrlPkg::reset: begin
        vectorCode = excCtrlPkg::vecReset;
        pcSelect   = pipeStagePkg::pcPlus8;
      end
      excCtrlPkg::fiq: begin
        vectorCode = excCtrlPkg::vecFiq;
        pcSelect   = pipeStagePkg::pcPlus4;
      end
      excCtrlPkg::irq: begin
        vectorCode = excCtrlPkg::vecIrq;
        pcSelect   = pipeStagePkg::pcPlus4;
      end
      excCtrlPkg::dataAbort: begin
        vectorCode = excCtrlPkg::vecData;
        pcSelect   = pipeStagePkg::pcPlus0;
      end
      excCtrlPkg::prefetchAbort: begin
        vectorCode = excCtrlPkg::vecPrefetch;
        pcSelect   = pipeStagePkg::pcPlus0;
      end
      excCtrlPkg::swi: begin
        vectorCode = excCtrlPkg::vecSwi;
        pcSelect   = pipeStagePkg::pcPlus0;
      end
      excCtrlPkg::undef: begin
        vectorCode = excCtrlPkg::vecUndef;
        pcSelect   = pipeStagePkg::pcPlus0;
      end
      default: begin
        // Fetch mux ignores the code while savePc is low
        vectorCode = excCtrlPkg::vecReset;
        pcSelect   = pipeStagePkg::pcPlus8;
      end
    endcase
  end

  assign savePc = (active != excCtrlPkg::none);

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the exception unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exceptionUnit_tb \
  -f exceptionUnit.f -o simExe || { echo "Build failed"; exit 1; }

out=$(./obj_dir/simExe 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1

/* tb/exceptionUnit_asserts.sv */
`timescale 1ns/1ps

module exceptionUnit_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   fiqReq,
  input logic                   irqReq,
  input logic                   stallW,
  input pipeStagePkg::pipeStage drainStage,
  input logic                   fiqTake,
  input logic                   irqTake,
  input logic                   fiqAck,
  input logic                   irqAck,
  input logic                   flushD,
  input logic                   flushE,
  input logic                   flushM,
  input logic                   flushW,
  input logic                   resetMicrop
);

  // Ack rises only once the drain counter saw the last good instruction leave W
  fiqAckRise: assert property (@(posedge clk) disable iff (reset)
    $rose(fiqAck) |-> $past(fiqReq && drainStage == pipeStagePkg::stageW && !stallW))
    else $error("fiqAck rose before the drain reached W");
  irqAckRise: assert property (@(posedge clk) disable iff (reset)
    $rose(irqAck) |-> $past(irqReq && drainStage == pipeStagePkg::stageW && !stallW))
    else $error("irqAck rose before the drain reached W");

  // Take cycle refetches from the vector, only D is flushed
  takeFlush: assert property (@(posedge clk) disable iff (reset)
    (fiqTake || irqTake) |-> flushD && !flushE && !flushM && !flushW)
    else $error("wrong flushes on an interrupt take");

  // Second data abort cycle flushes D, M and W and keeps E
  abortFlush: assert property (@(posedge clk) disable iff (reset)
    resetMicrop |=> flushD && !flushE && flushM && flushW)
    else $error("data abort second cycle has wrong flushes");

endmodule

bind excSequencer exceptionUnit_asserts asserts0 (.*);

/* tb/exceptionUnit_tb.sv */
`timescale 1ns/1ps

module exceptionUnit_tb;

  // Event kinds of a table row
  localparam int evData = 0, evUndef = 1, evSwi = 2, evPabt = 3, evFiq = 4;
  localparam int evIrq = 5, evBoth = 6, evSwiIrq = 7, evDrop = 8, evMasked = 9;
  // Stalled stage: 0 none, 1 E, 2 M, 3 W
  localparam int noVec = -1;

  logic clk, reset;
  logic undefE, swiE, prefetchAbortE, dataAbortM;
  logic stallD, stallE, stallM, stallW, pcWrPendingF, pcUpdateW;
  logic irqEnabled, fiqEnabled, fiqReq, irqReq, fiqAck, irqAck;
  logic flushD, flushE, flushM, flushW, stallOutD, resetMicrop, interrupting;
  logic [excCtrlPkg::vecBits-1:0] vectorCode;
  pipeStagePkg::pcSel pcSelect;
  logic savePc;

  int rowEvent[$], rowStall[$], rowStart[$], rowVec[$], rowPc[$], rowBase[$];
  int errors = 0, checks = 0, cycles = 0, limit = 0;
  int stallLen, gap, lat, seedVal;
  bit held, isExc;

  tbClockGen clkGen0 (.clk(clk), .reset(reset));
  exceptionUnit dut0 (.*);

  task addRow(input int ev, input int st, input int start, input int vec, input int pc,
              input int base);
    rowEvent.push_back(ev);
    rowStall.push_back(st);
    rowStart.push_back(start);
    rowVec.push_back(vec);
    rowPc.push_back(pc);
    rowBase.push_back(base);
  endtask

  task checkBit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task checkVal(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task clearInputs();
    {undefE, swiE, prefetchAbortE, dataAbortM} = 4'b0000;
    {stallD, stallE, stallM, stallW, pcWrPendingF, pcUpdateW} = 6'b000000;
    {fiqReq, irqReq} = 2'b00;
    {irqEnabled, fiqEnabled} = 2'b11;
  endtask

  task applyEvent(input int ev, input bit on);
    dataAbortM     = on && ev == evData;
    undefE         = on && ev == evUndef;
    swiE           = on && (ev == evSwi || ev == evSwiIrq);
    prefetchAbortE = on && ev == evPabt;
    fiqReq         = on && (ev == evFiq || ev == evBoth || ev == evDrop);
    irqReq         = on && (ev == evIrq || ev == evBoth || ev == evSwiIrq || ev == evMasked);
  endtask

  // Back-pressure from a stage also holds every stage before it
  task driveStall(input int st, input bit on);
    stallE = on && st >= 1;
    stallM = on && st >= 2;
    stallW = on && st == 3;
  endtask

  // Four-phase ack after a take, request dropped on the third cycle
  task handshake(input bit useFiq);
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      if (k == 2) applyEvent(evData, 1'b0);
      #10;
      checkBit(useFiq ? "fiqAck" : "irqAck", useFiq ? fiqAck : irqAck, k < 3);
      checkBit(useFiq ? "irqAck" : "fiqAck", useFiq ? irqAck : fiqAck, 1'b0);
    end
  endtask

  // Base latency counts from the cycle the event is first seen
  initial begin
    clearInputs();
    seedVal = $urandom(32'h71da0a2f);
    addRow(evData, 0, 0, excCtrlPkg::vecData, pipeStagePkg::pcPlus0, 1);
    addRow(evUndef, 3, 1, excCtrlPkg::vecUndef, pipeStagePkg::pcPlus0, 2);
    addRow(evSwi, 3, 1, excCtrlPkg::vecSwi, pipeStagePkg::pcPlus0, 2);
    addRow(evPabt, 3, 1, excCtrlPkg::vecPrefetch, pipeStagePkg::pcPlus0, 2);
    addRow(evFiq, 1, 1, excCtrlPkg::vecFiq, pipeStagePkg::pcPlus4, 3);
    addRow(evIrq, 2, 2, excCtrlPkg::vecIrq, pipeStagePkg::pcPlus4, 3);
    addRow(evBoth, 3, 3, excCtrlPkg::vecFiq, pipeStagePkg::pcPlus4, 3);
    addRow(evSwiIrq, 3, 1, excCtrlPkg::vecSwi, pipeStagePkg::pcPlus0, 2);
    addRow(evDrop, 0, 0, noVec, 0, 6);
    addRow(evMasked, 0, 0, noVec, 0, 6);
    addRow(evIrq, 1, 1, excCtrlPkg::vecIrq, pipeStagePkg::pcPlus4, 3);
    addRow(evData, 0, 0, excCtrlPkg::vecData, pipeStagePkg::pcPlus0, 1);
    // Worst case per row: stall 3, handshake 4, gap 4, setup 2
    limit = 30 + 50;
    foreach (rowBase[i]) limit += rowBase[i] + 13;

    @(negedge clk);
    #10;
    checkVal("vectorCode", vectorCode, excCtrlPkg::vecReset);
    checkBit("savePc", savePc, 1'b1);
    checkVal("flushes", {flushD, flushE, flushM, flushW}, 0);
    checkVal("acks", {fiqAck, irqAck, stallOutD, resetMicrop}, 0);
    wait (!reset);
    @(negedge clk);
    #10;
    checkVal("flushes", {flushD, flushE, flushM, flushW}, 0);
    checkVal("acks", {fiqAck, irqAck, stallOutD}, 0);
    checkBit("interrupting", interrupting, 1'b0);

    foreach (rowEvent[r]) begin
      if (rowEvent[r] == evMasked) begin
        @(negedge clk);
        irqEnabled = 1'b0;
      end
      stallLen = (rowStall[r] != 0) ? int'($urandom % 4) : 0;
      lat = rowBase[r] + stallLen;
      held = rowEvent[r] inside {evFiq, evIrq, evBoth, evMasked};
      isExc = rowEvent[r] inside {evUndef, evSwi, evPabt, evSwiIrq};
      for (int c = 0; c <= lat; c++) begin
        @(negedge clk);
        applyEvent(rowEvent[r], c == 0 || held || (rowEvent[r] == evDrop && c < 2));
        driveStall(rowStall[r], c >= rowStart[r] && c < rowStart[r] + stallLen);
        #10;
        if (c == 0 && rowEvent[r] == evData) begin
          checkVal("flushes", {flushD, flushE, flushM, flushW}, 15);
          checkVal("stallOutD,resetMicrop", {stallOutD, resetMicrop}, 3);
        end
        if (c == 0 && isExc) begin
          checkVal("flushes", {flushD, flushE, flushM, flushW}, 14);
          checkBit("stallOutD", stallOutD, 1'b1);
        end
        if (rowEvent[r] == evSwiIrq || rowVec[r] == noVec) begin
          checkVal("acks", {fiqAck, irqAck}, 0);
        end
        if (c < lat || rowVec[r] == noVec) begin
          checkBit("savePc", savePc, 1'b0);
        end else begin
          checkBit("savePc", savePc, 1'b1);
          checkVal("vectorCode", vectorCode, rowVec[r]);
          checkVal("pcSelect", pcSelect, rowPc[r]);
          checkBit("interrupting", interrupting, 1'b1);
        end
      end
      if (held && rowVec[r] != noVec) handshake(rowEvent[r] != evIrq);
      gap = int'($urandom % 4);
      repeat (gap + 1) begin
        @(negedge clk);
        clearInputs();
      end
    end

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Run limit derived from the table
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run passed %0d cycles without finishing", limit);
      $display("checks=%0d errors=%0d", checks, errors + 1);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

/* tb/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
  output logic clk,
  output logic reset
);

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  end

endmodule
